// File: Makefile
# Verilator build and run for the sprite display testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module tb_sprite_display

# the run fails unless the pass message shows up in the output
run: compile
	./obj_dir/Vtb_sprite_display | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null

clean:
	rm -rf obj_dir

// File: source/display_pkg.sv
// **************************************************
// display frame timing, screen coordinate and
// colour types, two-colour palette
// **************************************************

package display_pkg;

    localparam int coord_w = 16;                  // screen coordinate width

    typedef logic signed [coord_w-1:0] coord_t;   // signed screen position
    typedef logic [11:0] colour_t;                // 4 bits each of r, g, b

    // horizontal timing, one pixel per clock
    localparam coord_t h_active     = 64;         // visible pixels per line
    localparam coord_t h_total      = 80;         // clocks per line
    localparam coord_t h_sync_start = 68;         // first hsync cycle
    localparam coord_t h_sync_end   = 71;         // last hsync cycle, inclusive

    // vertical timing in lines
    localparam coord_t v_active     = 48;         // visible lines
    localparam coord_t v_total      = 56;         // lines per frame
    localparam coord_t v_sync_start = 50;         // first vsync line
    localparam coord_t v_sync_end   = 51;         // last vsync line, inclusive

    localparam colour_t sprite_colour = 12'hfc0;  // foreground, amber
    localparam colour_t back_colour   = 12'h137;  // background, dark blue

endpackage

// File: source/display_timing.sv
// **************************************************
// display timing generator: scan counters, sync,
// data enable, line and frame strobes
// **************************************************

`timescale 1ns/100ps

module display_timing
    import display_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    output coord_t sx,     // horizontal scan position
    output coord_t sy,     // vertical scan position
    output logic   hsync,  // active high
    output logic   vsync,  // active high
    output logic   de,     // inside visible area
    output logic   line,   // strobe at the start of each line
    output logic   frame   // strobe at the start of each frame
);

    logic last_col;  // final clock of a line
    logic last_row;  // final line of a frame

    assign last_col = (sx == h_total - coord_t'(1));
    assign last_row = (sy == v_total - coord_t'(1));

    always_ff @(posedge clk) begin
        if (last_col) begin
            sx <= '0;                                // wrap to next line
            sy <= last_row ? '0 : sy + coord_t'(1);  // wrap to next frame
        end else begin
            sx <= sx + coord_t'(1);
        end

        if (rst) begin
            sx <= '0;
            sy <= '0;
        end
    end

    // sync windows are inclusive at both ends
    assign hsync = (sx >= h_sync_start) && (sx <= h_sync_end);
    assign vsync = (sy >= v_sync_start) && (sy <= v_sync_end);
    assign de    = (sx < h_active) && (sy < v_active);  // origin is top left

    assign line  = (sx == '0);
    assign frame = (sx == '0) && (sy == '0);  // first pixel of line 0

endmodule

// File: source/sprite_control.sv
// **************************************************
// sprite position capture and drawing state
// machine, rom addressing and pixel gating
// **************************************************

`timescale 1ns/100ps

module sprite_control
    import display_pkg::*;
    import sprite_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      frame,     // start of frame strobe
    input  logic      line,      // start of line strobe
    input  coord_t    sx,        // current scan column
    input  coord_t    sy,        // current scan line
    input  coord_t    sprx,      // requested sprite column
    input  coord_t    spry,      // requested sprite row
    input  logic      spr_data,  // rom bit at spr_addr
    output spr_addr_t spr_addr,  // rom address
    output logic      pix        // sprite pixel, 0 outside draw
);

    coord_t     spr_col;     // column held for the whole frame
    coord_t     spr_row;     // row held for the whole frame
    coord_t     row_cmp;     // row seen by the idle test
    spr_ox_t    ox;          // column within sprite
    spr_oy_t    oy;          // line within sprite
    logic       last_pixel;  // ox at the right edge
    logic       last_line;   // oy at the bottom edge
    spr_state_t state;
    spr_state_t state_next;

    // position only moves at frame start
    always_ff @(posedge clk) begin
        if (frame) begin
            spr_col <= sprx;
            spr_row <= spry;
        end
    end

    // at frame start the new row is not latched yet, so a sprite on line 0
    // has to be matched against the input directly
    assign row_cmp = frame ? spry : spr_row;

    always_ff @(posedge clk) begin
        state <= state_next;

        case (state)
            start: begin
                oy       <= '0;
                spr_addr <= '0;              // top left pixel of the graphic
            end
            await_pos: ox <= '0;
            draw: begin
                ox       <= ox + spr_ox_t'(1);
                spr_addr <= spr_addr + spr_addr_t'(1);  // row major walk
            end
            next_line: oy <= oy + spr_oy_t'(1);
            default: ;                       // idle holds offsets
        endcase

        if (rst) begin
            state    <= idle;
            ox       <= '0;
            oy       <= '0;
            spr_addr <= '0;
        end
    end

    assign last_pixel = (ox == spr_ox_t'(spr_width - 1));
    assign last_line  = (oy == spr_oy_t'(spr_height - 1));

    always_comb begin
        case (state)
            idle:      state_next = (line && (sy == row_cmp)) ? start : idle;
            start:     state_next = await_pos;
            // one clock early so draw lines up with the column
            await_pos: state_next = (sx == spr_col - coord_t'(1)) ? draw : await_pos;
            draw:      state_next = !last_pixel ? draw :
                                    (!last_line ? next_line : idle);
            next_line: state_next = await_pos;
            default:   state_next = idle;
        endcase
    end

    assign pix = (state == draw) ? spr_data : 1'b0;  // rom bit only while drawing

endmodule

// File: source/sprite_display.sv
// **************************************************
// sprite display top: timing, control, rom and
// output stage
// **************************************************

`timescale 1ns/100ps

module sprite_display
    import display_pkg::*;
    import sprite_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  coord_t  sprx,    // sprite column, taken at frame start
    input  coord_t  spry,    // sprite row, taken at frame start
    output colour_t rgb,
    output logic    hsync,
    output logic    vsync,
    output logic    de,
    output coord_t  out_sx,  // position of rgb
    output coord_t  out_sy
);

    coord_t    scan_x;     // scan position from timing
    coord_t    scan_y;
    logic      scan_hs;
    logic      scan_vs;
    logic      scan_de;
    logic      scan_line;
    logic      scan_frame;
    spr_addr_t spr_addr;   // control to rom
    logic      spr_data;   // rom to control
    logic      pix;        // gated sprite bit

    display_timing u_timing (
        .clk   (clk),
        .rst   (rst),
        .sx    (scan_x),
        .sy    (scan_y),
        .hsync (scan_hs),
        .vsync (scan_vs),
        .de    (scan_de),
        .line  (scan_line),
        .frame (scan_frame)
    );

    sprite_control u_control (
        .clk      (clk),
        .rst      (rst),
        .frame    (scan_frame),
        .line     (scan_line),
        .sx       (scan_x),
        .sy       (scan_y),
        .sprx     (sprx),
        .spry     (spry),
        .spr_data (spr_data),
        .spr_addr (spr_addr),
        .pix      (pix)
    );

    sprite_rom u_rom (
        .addr (spr_addr),
        .data (spr_data)
    );

    sprite_pixel_out u_pixel_out (
        .clk       (clk),
        .rst       (rst),
        .pix       (pix),
        .de        (scan_de),
        .hsync     (scan_hs),
        .vsync     (scan_vs),
        .sx        (scan_x),
        .sy        (scan_y),
        .rgb       (rgb),
        .out_hsync (hsync),
        .out_vsync (vsync),
        .out_de    (de),
        .out_sx    (out_sx),
        .out_sy    (out_sy)
    );

endmodule

// File: source/sprite_pixel_out.sv
// **************************************************
// palette lookup, blanking, output register stage
// **************************************************

`timescale 1ns/100ps

module sprite_pixel_out
    import display_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    pix,        // sprite bit
    input  logic    de,         // visible area
    input  logic    hsync,
    input  logic    vsync,
    input  coord_t  sx,         // scan position of this pixel
    input  coord_t  sy,
    output colour_t rgb,        // registered colour
    output logic    out_hsync,  // delayed with rgb
    output logic    out_vsync,
    output logic    out_de,
    output coord_t  out_sx,     // position of the rgb value
    output coord_t  out_sy
);

    colour_t colour;  // palette result before the register

    assign colour = !de ? colour_t'(0) :               // black in blanking
                    (pix ? sprite_colour : back_colour);

    always_ff @(posedge clk) begin
        rgb       <= colour;
        out_hsync <= hsync;
        out_vsync <= vsync;
        out_de    <= de;

        if (rst) begin
            rgb       <= '0;
            out_hsync <= 1'b0;
            out_vsync <= 1'b0;
            out_de    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        out_sx <= sx;  // same stage as rgb
        out_sy <= sy;
    end

endmodule

// File: source/sprite_pkg.sv
// **************************************************
// sprite size, rom address and offset types,
// drawing state machine encoding
// **************************************************

package sprite_pkg;

    localparam int spr_width  = 8;                       // graphic width in pixels
    localparam int spr_height = 8;                       // graphic height in lines
    localparam int spr_depth  = spr_width * spr_height;  // one bit per pixel

    typedef logic [$clog2(spr_depth)-1:0]  spr_addr_t;   // rom address
    typedef logic [$clog2(spr_width)-1:0]  spr_ox_t;     // column within sprite
    typedef logic [$clog2(spr_height)-1:0] spr_oy_t;     // line within sprite

    typedef enum logic [2:0] {
        idle,       // waiting for the sprite's first line
        start,      // reset line and rom address
        await_pos,  // wait for the column on this line
        draw,       // one sprite pixel per clock
        next_line   // step to the next sprite line
    } spr_state_t;

    // graphic file, path taken from the project root
    localparam string spr_mem_file = "source/sprite_rom.mem";

endpackage

// File: source/sprite_rom.mem
// 8x8 sprite graphic, one sprite row per line, leftmost pixel first, 1 is foreground
1 1 1 1 1 1 0 0
1 1 0 0 0 0 0 0
1 1 0 0 0 0 0 0
1 1 1 1 1 0 0 0
1 1 0 0 0 0 0 0
1 1 0 0 0 0 0 1
1 1 0 0 0 0 1 1
1 1 0 0 0 1 1 1

// File: source/sprite_rom.sv
// **************************************************
// one-bit sprite graphic rom, async read
// **************************************************

`timescale 1ns/100ps

module sprite_rom
    import sprite_pkg::*;
(
    input  spr_addr_t addr,  // pixel index, row major
    output logic      data   // pixel bit, 1 is foreground
);

    logic rom [0:spr_depth-1];  // 8x8 graphic, one bit per entry

    initial begin
        $readmemb(spr_mem_file, rom);  // graphic held in a text file
    end

    assign data = rom[addr];  // no read latency

endmodule

// File: src.f
source/display_pkg.sv
source/sprite_pkg.sv
source/display_timing.sv
source/sprite_rom.sv
source/sprite_control.sv
source/sprite_pixel_out.sv
source/sprite_display.sv
test/sprite_display_sva.sv
test/tb_sprite_display.sv

// File: test/sprite_display_sva.sv
// **************************************************
// bound assertions: sprite pixel gating, draw run
// length, output blanking
// **************************************************

`timescale 1ns/100ps

module sprite_display_sva
    import display_pkg::*;
    import sprite_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input spr_state_t state,  // control fsm state
    input logic       de,     // scan enable, before the output register
    input colour_t    rgb     // registered colour
);

    logic [3:0] run_len;  // consecutive draw cycles so far

    always_ff @(posedge clk) begin
        if (state == draw) begin
            run_len <= run_len + 4'd1;
        end else begin
            run_len <= '0;  // run broken
        end

        if (rst) begin
            run_len <= '0;
        end
    end

    // sprite colour only ever follows a draw cycle
    a_pix_outside_draw: assert property (@(posedge clk) disable iff (rst)
        (state != draw) |=> (rgb != sprite_colour))
        else $error("sprite colour shown for a pixel outside draw");

    // never longer than one sprite line
    a_draw_max: assert property (@(posedge clk) disable iff (rst)
        (state == draw) |-> (run_len < 4'(spr_width)))
        else $error("draw lasted more than one sprite line");

    // on leaving draw the run has exactly one line of pixels
    a_draw_exact: assert property (@(posedge clk) disable iff (rst)
        ((state != draw) && (run_len != '0)) |-> (run_len == 4'(spr_width)))
        else $error("draw left after a wrong number of cycles");

    a_blanking: assert property (@(posedge clk) disable iff (rst)
        !de |=> (rgb == '0))
        else $error("colour not black during blanking");

endmodule

// scan enable is a top level wire, the state sits in the control block
bind sprite_display sprite_display_sva u_sva (
    .clk   (clk),
    .rst   (rst),
    .state (u_control.state),
    .de    (scan_de),
    .rgb   (rgb)
);

// File: test/tb_sprite_display.sv
// **************************************************
// testbench for the sprite display: clock, reset,
// stimulus, reference colour model, output checker
// **************************************************

`timescale 1ns/100ps

module tb_sprite_display
    import display_pkg::*;
    import sprite_pkg::*;
();

    localparam int frame_timeout = 2 * h_total * v_total;  // cycles allowed per wait

    logic    clk = 1'b0;
    logic    rst;
    coord_t  sprx;
    coord_t  spry;
    colour_t rgb;
    logic    hsync;
    logic    vsync;
    logic    de;
    coord_t  out_sx;
    coord_t  out_sy;

    logic    ref_rom [0:spr_depth-1];   // own copy of the graphic
    integer  seed;
    logic    checking;                  // set once the first edge has passed
    logic    rst_seen = 1'b1;           // rst as the last edge saw it
    coord_t  last_x;                    // inputs as the next edge will see them
    coord_t  last_y;
    coord_t  cap_x;                     // position held for the current frame
    coord_t  cap_y;
    coord_t  pos_x;                     // scan position the next output should show
    coord_t  pos_y;
    logic    exp_de;
    logic    exp_hs;
    logic    exp_vs;
    colour_t exp_colour;
    int      fg_count;                  // foreground pixels seen
    coord_t  edge_x [4] = '{3, 56, 3, 56};
    coord_t  edge_y [4] = '{0, 40, 40, 0};

    always #10 clk = ~clk;  // 20 ns period

    sprite_display uut (
        .clk    (clk),
        .rst    (rst),
        .sprx   (sprx),
        .spry   (spry),
        .rgb    (rgb),
        .hsync  (hsync),
        .vsync  (vsync),
        .de     (de),
        .out_sx (out_sx),
        .out_sy (out_sy)
    );

    task automatic fail_run(string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s: got %h, expected %h at x %0d y %0d",
                               name, actual, expected, out_sx, out_sy));
        end
    endtask

    // palette and sprite rectangle rule
    function automatic colour_t expected_rgb(coord_t x, coord_t y, logic vis,
                                             coord_t cx, coord_t cy);
        coord_t    dx;
        coord_t    dy;
        spr_addr_t idx;
        dx  = x - cx;
        dy  = y - cy;
        idx = spr_addr_t'(dy * spr_width + dx);  // row major like the graphic file
        if (!vis) begin
            return '0;  // blanking
        end
        if ((dx >= coord_t'(0)) && (dx < coord_t'(spr_width)) &&
            (dy >= coord_t'(0)) && (dy < coord_t'(spr_height)) && ref_rom[idx]) begin
            return sprite_colour;
        end
        return back_colour;
    endfunction

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            if (rst_seen) begin
                check_value("rgb", rgb, '0);  // reset values
                check_value("hsync", hsync, '0);
                check_value("vsync", vsync, '0);
                check_value("de", de, '0);
                pos_x = '0;                   // first output after reset is the origin
                pos_y = '0;
            end else begin
                check_value("out_sx", out_sx, pos_x);
                check_value("out_sy", out_sy, pos_y);
                if ((pos_x == '0) && (pos_y == '0)) begin
                    cap_x = last_x;  // frame start took these
                    cap_y = last_y;
                end
                exp_de = (pos_x < h_active) && (pos_y < v_active);
                exp_hs = (pos_x >= h_sync_start) && (pos_x <= h_sync_end);
                exp_vs = (pos_y >= v_sync_start) && (pos_y <= v_sync_end);
                check_value("de", de, exp_de);
                check_value("hsync", hsync, exp_hs);
                check_value("vsync", vsync, exp_vs);
                exp_colour = expected_rgb(pos_x, pos_y, exp_de, cap_x, cap_y);
                check_value("rgb", rgb, exp_colour);
                if (exp_colour == sprite_colour) begin
                    fg_count++;
                end
                if (pos_x == h_total - coord_t'(1)) begin
                    pos_x = '0;  // next line
                    pos_y = (pos_y == v_total - coord_t'(1)) ? coord_t'(0) : pos_y + coord_t'(1);
                end else begin
                    pos_x = pos_x + coord_t'(1);
                end
            end
            rst_seen = rst;
            last_x   = sprx;
            last_y   = spry;
        end
    end

    // returns on the rising edge after the first pixel of a frame leaves
    task automatic wait_frame();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > frame_timeout) begin
                fail_run("timed out waiting for the start of a frame");
            end
        end while (!((out_sx == '0) && (out_sy == '0) && de));
        @(posedge clk);
    endtask

    task automatic wait_row(coord_t row);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > frame_timeout) begin
                fail_run("timed out waiting for a scan line");
            end
        end while (out_sy != row);
        @(posedge clk);
    endtask

    initial begin
        int i;
        rst      = 1'b1;
        sprx     = 16'sd20;
        spry     = 16'sd10;
        checking = 1'b0;
        fg_count = 0;
        seed     = 32'he4f2;
        $readmemb(spr_mem_file, ref_rom);

        @(posedge clk);
        checking = 1'b1;
        repeat (15) @(posedge clk);
        rst <= 1'b0;

        wait_frame();
        wait_frame();                     // one whole frame at (20,10)

        sprx <= 16'sd10;                  // taken at the next frame
        spry <= 16'sd5;
        wait_frame();
        wait_row(16'sd24);
        sprx <= 16'sd40;                  // mid frame, old position stays
        spry <= 16'sd30;
        wait_frame();

        for (i = 0; i < 8; i++) begin
            if (i < 4) begin
                sprx <= edge_x[i];        // corner positions first
                spry <= edge_y[i];
            end else begin
                sprx <= coord_t'(3 + ($unsigned($random(seed)) % 54));
                spry <= coord_t'($unsigned($random(seed)) % 41);
            end
            wait_frame();
        end
        wait_frame();                     // finish the last random frame

        if (fg_count == 0) begin
            fail_run("no sprite pixel was drawn in any frame");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule
